// ==== verif/cache_testdata.txt ====
# op addr data fill wb wb_addr (addr, data and wb_addr in hex)
# fill and wb count the expected memory reads and write-backs of the request
R 0100 A5A50100 1 0 0000
R 0103 A5A50103 0 0 0000
W 0101 DEADBEEF 0 0 0000
R 0100 A5A50100 0 0 0000
R 0101 DEADBEEF 0 0 0000
R 0102 A5A50102 0 0 0000
R 0103 A5A50103 0 0 0000
W 0208 12345678 1 0 0000
R 020A A5A5020A 0 0 0000
R 0208 12345678 0 0 0000
W 0014 11110001 1 0 0000
W 0024 22220002 1 0 0000
R 0034 A5A50034 1 0 0000
W 0044 44440004 1 0 0000
R 0014 11110001 0 0 0000
R 0044 44440004 0 0 0000
R 0054 A5A50054 1 1 0024
R 0064 A5A50064 1 0 0000
R 0024 22220002 1 1 0014
R 0025 A5A50025 0 0 0000
R 0014 11110001 1 1 0044
R 0200 A5A50200 1 0 0000
R 0300 A5A50300 1 0 0000
R 0400 A5A50400 1 0 0000
R 0500 A5A50500 1 1 0100
R 0101 DEADBEEF 1 0 0000
R 0044 44440004 1 0 0000

// ==== filelist.f ====
common/cache_pkg.sv
ways/way_array.sv
ways/way_lookup.sv
hw/cache_fsm.sv
hw/cache_ctrl_top.sv
verif/mem_model.sv
verif/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/cache_tb.sv ====
module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;                  // Cycles allowed for any one wait

  logic             clk, rst_n;
  logic             cpu_req_valid, cpu_req_ready, cpu_req_write;
  cache_pkg::addr_t cpu_req_addr;
  cache_pkg::word_t cpu_req_wdata, cpu_resp_rdata;
  logic             cpu_resp_valid, cpu_resp_ready;
  logic             mem_req_valid, mem_req_ready, mem_req_write, mem_resp_valid;
  cache_pkg::addr_t mem_req_addr, last_wr_addr;
  cache_pkg::line_t mem_req_wdata, mem_resp_rdata;
  cache_pkg::word_t last_wr_word0;
  int               wr_count, rd_count;
  integer           seed;
  int               mismatches, timeouts, others;
  cache_pkg::word_t shadow [cache_pkg::addr_t];  // Every word written so far

  cache_ctrl_top dut0 (.*);

  mem_model mem0 (
    .clk, .rst_n,
    .req_valid(mem_req_valid), .req_ready(mem_req_ready), .req_write(mem_req_write),
    .req_addr(mem_req_addr), .req_wdata(mem_req_wdata),
    .resp_valid(mem_resp_valid), .resp_rdata(mem_resp_rdata),
    .wr_count, .rd_count, .last_wr_addr, .last_wr_word0
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                      // 40 ns period
  end

  task automatic check_word(string name, cache_pkg::word_t expected, cache_pkg::word_t actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_addr(string name, cache_pkg::addr_t expected, cache_pkg::addr_t actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      mismatches++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts, others);
    if (mismatches == 0 && timeouts == 0 && others == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  task automatic abort_on_timeout(string what);
    timeouts++;
    $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
    finish_run();
  endtask

  // Memory start rule unless a write replaced the word
  function automatic cache_pkg::word_t expected_word(cache_pkg::addr_t a);
    if (shadow.exists(a))
      return shadow[a];
    return {16'hA5A5, a};
  endfunction

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_request(logic write, cache_pkg::addr_t addr, cache_pkg::word_t wdata);
    int n;
    n = 0;
    while (cpu_req_ready !== 1'b1) begin
      if (n == TIMEOUT)
        abort_on_timeout("cpu_req_ready");
      @(negedge clk);
      n++;
    end
    cpu_req_valid = 1'b1;
    cpu_req_write = write;
    cpu_req_addr  = addr;
    cpu_req_wdata = wdata;
    @(negedge clk);                              // Ready was high across the rising edge
    cpu_req_valid = 1'b0;
  endtask

  // Holds cpu_resp_ready low for 0 to 3 valid cycles and then takes one response
  task automatic receive_response(string name, cache_pkg::word_t expected, output int latency);
    int               n, hold_left;
    logic             seen, done;
    cache_pkg::word_t first_rdata;
    n           = 0;
    seen        = 1'b0;
    done        = 1'b0;
    first_rdata = '0;
    latency     = 0;
    hold_left   = {$random(seed)} % 4;
    cpu_resp_ready = 1'b0;
    while (!done) begin
      if (n == TIMEOUT)
        abort_on_timeout("cpu_resp_valid");
      @(negedge clk);
      n++;
      if (cpu_resp_valid) begin
        if (!seen) begin
          first_rdata = cpu_resp_rdata;
          latency     = n;
        end else begin
          check_word({name, " held rdata"}, first_rdata, cpu_resp_rdata);
        end
        check_bit({name, " cpu_req_ready during response"}, 1'b0, cpu_req_ready);
        seen = 1'b1;
        if (hold_left == 0) begin
          cpu_resp_ready = 1'b1;                 // Handshake on the next rising edge
          done = 1'b1;
        end else begin
          hold_left--;
        end
      end
    end
    check_word(name, expected, first_rdata);
    @(negedge clk);
    cpu_resp_ready = 1'b0;
    check_bit({name, " single response"}, 1'b0, cpu_resp_valid);
  endtask

  initial begin
    int               fd, code, fill, wb, wr_before, rd_before, latency, line_no;
    logic [7:0]       op;
    cache_pkg::addr_t addr, wb_addr;
    cache_pkg::word_t data, expected, wb_word;
    string            text, name;
    seed = 1;
    mismatches = 0;
    timeouts = 0;
    others = 0;
    rst_n = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req_write = 1'b0;
    cpu_req_addr = '0;
    cpu_req_wdata = '0;
    cpu_resp_ready = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("reset cpu_req_ready", 1'b1, cpu_req_ready);
    check_bit("reset cpu_resp_valid", 1'b0, cpu_resp_valid);
    check_bit("reset mem_req_valid", 1'b0, mem_req_valid);

    fd = $fopen("verif/cache_testdata.txt", "r");
    if (fd == 0) begin
      others++;
      $display("Could not open verif/cache_testdata.txt for reading");
    end else begin
      line_no = 0;
      while ($fgets(text, fd) != 0) begin
        line_no++;
        if (text.len() < 2 || text[0] == "#")
          continue;
        code = $sscanf(text, "%c %h %h %d %d %h", op, addr, data, fill, wb, wb_addr);
        if (code != 6 || (op != "R" && op != "W")) begin
          others++;
          $display("Line %0d of the data file could not be parsed", line_no);
          continue;
        end
        name = $sformatf("line %0d %s %h", line_no, (op == "W") ? "write" : "read", addr);
        wb_word = expected_word(wb_addr);        // Victim content before this access
        if (op == "R")
          check_word({name, " data column"}, expected_word(addr), data);
        else
          shadow[addr] = data;
        expected  = expected_word(addr);
        wr_before = wr_count;
        rd_before = rd_count;
        send_request(op == "W", addr, data);
        receive_response(name, expected, latency);
        check_count({name, " fill requests"}, fill, rd_count - rd_before);
        check_count({name, " write-backs"}, wb, wr_count - wr_before);
        if (wb == 1) begin
          check_addr({name, " write-back address"}, wb_addr, last_wr_addr);
          check_word({name, " write-back word 0"}, wb_word, last_wr_word0);
        end
        if (fill == 0 && wb == 0)
          check_count({name, " hit latency"}, 2, latency);  // Valid from the 2nd edge on
      end
      $fclose(fd);
    end
    finish_run();
  end

endmodule

// ==== verif/mem_model.sv ====
module mem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_valid,
  output logic             req_ready,
  input  logic             req_write,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::line_t req_wdata,
  output logic             resp_valid,
  output cache_pkg::line_t resp_rdata,
  output int               wr_count,       // Accepted line writes
  output int               rd_count,       // Accepted line reads
  output cache_pkg::addr_t last_wr_addr,
  output cache_pkg::word_t last_wr_word0
);
  timeunit 1ns;
  timeprecision 100ps;

  cache_pkg::word_t mem [cache_pkg::addr_t];  // Only words written so far
  integer           seed;
  int               delay;
  logic             is_write;
  cache_pkg::addr_t base;
  cache_pkg::line_t wline;

  // Untouched words read as A5A5 over their own address
  function automatic cache_pkg::word_t read_word(cache_pkg::addr_t a);
    if (mem.exists(a))
      return mem[a];
    return {16'hA5A5, a};
  endfunction

  initial begin
    seed          = 1;
    req_ready     = 1'b0;
    resp_valid    = 1'b0;
    resp_rdata    = '0;
    wr_count      = 0;
    rd_count      = 0;
    last_wr_addr  = '0;
    last_wr_word0 = '0;
    forever begin
      @(negedge clk);
      if (rst_n && req_valid) begin
        is_write = req_write;                  // Request is held until accepted
        base     = req_addr;
        wline    = req_wdata;
        delay    = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        req_ready = 1'b1;                      // Taken on the next rising edge
        @(negedge clk);
        req_ready = 1'b0;
        if (is_write) begin
          for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++)
            mem[base + cache_pkg::addr_t'(i)] = wline[i];
          wr_count++;
          last_wr_addr  = base;
          last_wr_word0 = wline[0];
        end else begin
          rd_count++;
          delay = {$random(seed)} % 4;
          repeat (delay) @(negedge clk);
          for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++)
            resp_rdata[i] = read_word(base + cache_pkg::addr_t'(i));
          resp_valid = 1'b1;                   // One-cycle pulse
          @(negedge clk);
          resp_valid = 1'b0;
        end
      end
    end
  end

endmodule

// ==== hw/cache_ctrl_top.sv ====
module cache_ctrl_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cpu_req_valid,
  output logic             cpu_req_ready,
  input  logic             cpu_req_write,
  input  cache_pkg::addr_t cpu_req_addr,
  input  cache_pkg::word_t cpu_req_wdata,
  output logic             cpu_resp_valid,
  input  logic             cpu_resp_ready,
  output cache_pkg::word_t cpu_resp_rdata,
  output logic             mem_req_valid,
  input  logic             mem_req_ready,
  output logic             mem_req_write,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::line_t mem_req_wdata,
  input  logic             mem_resp_valid,
  input  cache_pkg::line_t mem_resp_rdata
);

  cache_pkg::index_t    index;
  cache_pkg::tag_t      tag;
  cache_pkg::tag_set_t  tags;
  cache_pkg::line_set_t lines;
  cache_pkg::way_mask_t valids, dirtys;
  cache_pkg::age_set_t  ages, next_ages, wr_ages;
  logic                 hit, victim_dirty, fill;
  cache_pkg::way_mask_t hit_way, victim_way;
  cache_pkg::way_mask_t line_we;                    // Line write strobes, one per way
  cache_pkg::tag_t      wr_tag;
  cache_pkg::line_t     wr_line;
  logic                 wr_dirty, age_we;

  way_array array0 (
    .clk, .rst_n, .index, .tags, .lines, .valids, .dirtys, .ages,
    .line_we, .wr_tag, .wr_line, .wr_dirty, .age_we, .wr_ages
  );

  way_lookup lookup0 (
    .tag, .tags, .valids, .dirtys, .ages, .fill,
    .hit, .hit_way, .victim_way, .victim_dirty, .next_ages
  );

  cache_fsm fsm0 (
    .clk, .rst_n,
    .cpu_req_valid, .cpu_req_ready, .cpu_req_write, .cpu_req_addr, .cpu_req_wdata,
    .cpu_resp_valid, .cpu_resp_ready, .cpu_resp_rdata,
    .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_resp_valid, .mem_resp_rdata,
    .index, .tag, .lines, .tags, .hit, .hit_way, .victim_way, .victim_dirty, .next_ages,
    .fill, .line_we, .wr_tag, .wr_line, .wr_dirty, .age_we, .wr_ages
  );

endmodule

// ==== hw/cache_fsm.sv ====
module cache_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cpu_req_valid,
  output logic                  cpu_req_ready,
  input  logic                  cpu_req_write,
  input  cache_pkg::addr_t      cpu_req_addr,
  input  cache_pkg::word_t      cpu_req_wdata,
  output logic                  cpu_resp_valid,
  input  logic                  cpu_resp_ready,
  output cache_pkg::word_t      cpu_resp_rdata,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  output logic                  mem_req_write,
  output cache_pkg::addr_t      mem_req_addr,
  output cache_pkg::line_t      mem_req_wdata,
  input  logic                  mem_resp_valid,
  input  cache_pkg::line_t      mem_resp_rdata,
  output cache_pkg::index_t     index,
  output cache_pkg::tag_t       tag,
  input  cache_pkg::line_set_t  lines,
  input  cache_pkg::tag_set_t   tags,
  input  logic                  hit,
  input  cache_pkg::way_mask_t  hit_way,
  input  cache_pkg::way_mask_t  victim_way,
  input  logic                  victim_dirty,
  input  cache_pkg::age_set_t   next_ages,
  output logic                  fill,
  output cache_pkg::way_mask_t  line_we,
  output cache_pkg::tag_t       wr_tag,
  output cache_pkg::line_t      wr_line,
  output logic                  wr_dirty,
  output logic                  age_we,
  output cache_pkg::age_set_t   wr_ages
);

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_WB_REQ, S_FILL_REQ, S_FILL_WAIT, S_UPDATE, S_RESP
  } state_t;

  state_t             state, state_nxt;
  logic               miss_r;        // Current access took the fill path
  logic               write_r;
  cache_pkg::addr_t   addr_r;
  cache_pkg::word_t   wdata_r;
  cache_pkg::line_t   fill_line;     // Line returned by memory
  cache_pkg::word_t   rdata_r;
  cache_pkg::offset_t offset;
  cache_pkg::tag_t    victim_tag;
  cache_pkg::line_t   victim_line, hit_line, merged_line;

  // Split the registered address
  assign tag    = addr_r[cache_pkg::ADDR_BITS-1:cache_pkg::TAG_LSB];
  assign index  = addr_r[cache_pkg::TAG_LSB-1:cache_pkg::INDEX_LSB];
  assign offset = addr_r[cache_pkg::OFFSET_BITS-1:0];

  // One-hot muxes out of the addressed set
  always_comb begin
    victim_tag  = '0;
    victim_line = '0;
    hit_line    = '0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (victim_way[w]) begin
        victim_tag  = victim_tag | tags[w];
        victim_line = victim_line | lines[w];
      end
      if (hit_way[w])
        hit_line = hit_line | lines[w];
    end
  end

  // Word merge into hit line or fresh fill
  always_comb begin
    merged_line = miss_r ? fill_line : hit_line;
    if (write_r)
      merged_line[offset] = wdata_r;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:      if (cpu_req_valid) state_nxt = S_LOOKUP;
      S_LOOKUP:    state_nxt = hit ? S_UPDATE : (victim_dirty ? S_WB_REQ : S_FILL_REQ);
      S_WB_REQ:    if (mem_req_ready) state_nxt = S_FILL_REQ;   // Write done on accept
      S_FILL_REQ:  if (mem_req_ready) state_nxt = S_FILL_WAIT;
      S_FILL_WAIT: if (mem_resp_valid) state_nxt = S_UPDATE;
      S_UPDATE:    state_nxt = S_RESP;
      S_RESP:      if (cpu_resp_ready) state_nxt = S_IDLE;
      default:     state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      miss_r <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == S_LOOKUP)
        miss_r <= !hit;
    end
  end

  // Request, fill and response payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && cpu_req_valid) begin
      write_r <= cpu_req_write;
      addr_r  <= cpu_req_addr;
      wdata_r <= cpu_req_wdata;
    end
    if (state == S_FILL_WAIT && mem_resp_valid)
      fill_line <= mem_resp_rdata;
    if (state == S_UPDATE)
      rdata_r <= merged_line[offset];              // Written word on writes
  end

  assign cpu_req_ready  = (state == S_IDLE);
  assign cpu_resp_valid = (state == S_RESP);
  assign cpu_resp_rdata = rdata_r;

  // Memory side, line aligned addresses
  assign mem_req_valid = (state == S_WB_REQ) || (state == S_FILL_REQ);
  assign mem_req_write = (state == S_WB_REQ);
  assign mem_req_addr  = (state == S_WB_REQ) ? {victim_tag, index, cache_pkg::offset_t'(0)}
                                             : {tag, index, cache_pkg::offset_t'(0)};
  assign mem_req_wdata = victim_line;

  // Array update, read hits leave the line alone
  assign fill     = miss_r;
  assign line_we  = (state != S_UPDATE) ? '0 :
                    miss_r ? victim_way : (write_r ? hit_way : '0);
  assign wr_tag   = tag;
  assign wr_line  = merged_line;
  assign wr_dirty = write_r;                        // Read fill comes back clean
  assign age_we   = (state == S_UPDATE);
  assign wr_ages  = next_ages;

endmodule

// ==== ways/way_lookup.sv ====
module way_lookup (
  input  cache_pkg::tag_t      tag,
  input  cache_pkg::tag_set_t  tags,
  input  cache_pkg::way_mask_t valids,
  input  cache_pkg::way_mask_t dirtys,
  input  cache_pkg::age_set_t  ages,
  input  logic                 fill,
  output logic                 hit,
  output cache_pkg::way_mask_t hit_way,
  output cache_pkg::way_mask_t victim_way,
  output logic                 victim_dirty,
  output cache_pkg::age_set_t  next_ages
);

  cache_pkg::way_mask_t used_way;   // Way touched by this access
  cache_pkg::age_t      used_age;   // Its age before the access

  // Tag compare on every way, only valid ways count
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
      hit_way[w] = valids[w] && (tags[w] == tag);
  end

  assign hit = |hit_way;

  // LRU way carries the top age
  // Ages form a permutation so exactly one bit is set
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
      victim_way[w] = (ages[w] == cache_pkg::age_t'(cache_pkg::MAX_AGE));
  end

  // Write-back only needed for a valid, modified victim
  assign victim_dirty = |(victim_way & valids & dirtys);

  // Fill replaces the victim, otherwise the hit way is touched
  assign used_way = fill ? victim_way : hit_way;

  always_comb begin
    used_age = '0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (used_way[w])
        used_age = used_age | ages[w];               // One-hot select
    end
  end

  // Age update
  // Used way becomes newest
  // Ways younger than it shift back by one, older ones hold
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (used_way[w])
        next_ages[w] = '0;
      else if (ages[w] < used_age)
        next_ages[w] = ages[w] + cache_pkg::age_t'(1);
      else
        next_ages[w] = ages[w];
    end
  end

endmodule

// ==== ways/way_array.sv ====
module way_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::index_t     index,
  output cache_pkg::tag_set_t   tags,
  output cache_pkg::line_set_t  lines,
  output cache_pkg::way_mask_t  valids,
  output cache_pkg::way_mask_t  dirtys,
  output cache_pkg::age_set_t   ages,
  input  cache_pkg::way_mask_t  line_we,
  input  cache_pkg::tag_t       wr_tag,
  input  cache_pkg::line_t      wr_line,
  input  logic                  wr_dirty,
  input  logic                  age_we,
  input  cache_pkg::age_set_t   wr_ages
);

  // Storage, one entry per set
  cache_pkg::tag_set_t  tag_mem  [cache_pkg::NUM_SETS];
  cache_pkg::line_set_t data_mem [cache_pkg::NUM_SETS];
  cache_pkg::way_mask_t valid_q  [cache_pkg::NUM_SETS];
  cache_pkg::way_mask_t dirty_q  [cache_pkg::NUM_SETS];
  cache_pkg::age_set_t  age_q    [cache_pkg::NUM_SETS];

  // Combinational read of the addressed set
  assign tags   = tag_mem[index];
  assign lines  = data_mem[index];
  assign valids = valid_q[index];
  assign dirtys = dirty_q[index];
  assign ages   = age_q[index];

  // Tag and data payload
  always_ff @(posedge clk) begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (line_we[w]) begin
        tag_mem[index][w]  <= wr_tag;
        data_mem[index][w] <= wr_line;
      end
    end
  end

  // Bookkeeping bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
          age_q[s][w] <= cache_pkg::age_t'(w);      // Way i starts at age i
      end
    end else begin
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        if (line_we[w]) begin
          valid_q[index][w] <= 1'b1;                 // Any line write allocates
          dirty_q[index][w] <= wr_dirty;
        end
      end
      if (age_we)
        age_q[index] <= wr_ages;                     // Whole set at once
    end
  end

endmodule

// ==== common/cache_pkg.sv ====
package cache_pkg;

  // Geometry
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_BITS      = 32;
  localparam int ADDR_BITS      = 16;             // Word address, no byte offset

  // Address fields: tag | index | offset
  localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int INDEX_LSB   = OFFSET_BITS;      // Low bit of the index field
  localparam int TAG_LSB     = OFFSET_BITS + INDEX_BITS;

  // Oldest age in a set, marks the LRU way
  localparam int MAX_AGE = NUM_WAYS - 1;

  typedef logic [WORD_BITS-1:0]   word_t;
  typedef logic [ADDR_BITS-1:0]   addr_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;

  // Word 0 sits in the low bits
  typedef word_t [WORDS_PER_LINE-1:0] line_t;

  // 0 is most recently used
  typedef logic [$clog2(NUM_WAYS)-1:0] age_t;

  // Bit i selects way i
  typedef logic [NUM_WAYS-1:0] way_mask_t;

  // Per-set views, element i belongs to way i
  typedef age_t  [NUM_WAYS-1:0] age_set_t;
  typedef tag_t  [NUM_WAYS-1:0] tag_set_t;
  typedef line_t [NUM_WAYS-1:0] line_set_t;

endpackage
